//--- rtl/cnn_sender_defines.svh
// sender widths and sizes shared by the CNN first-layer window former

`ifndef CNN_SENDER_DEFINES_SVH
`define CNN_SENDER_DEFINES_SVH

// incoming grayscale pixel
`define PIXEL_W 8

// signed fixed-point feature-map value, bit 15 is the sign
`define FMAP_W 16

// side length of the convolution window
`define KERNEL_DIM 3

// largest image side, also the depth of each line buffer row
`define MAX_IMG_DIM 30

// enough bits for a coordinate up to MAX_IMG_DIM - 1
`define COORD_W 5

// nine packed feature-map values
`define WINDOW_W (`KERNEL_DIM * `KERNEL_DIM * `FMAP_W)

// weight bank address width
`define WT_ADDR_W 11

// config register port
`define CFG_ADDR_W 2
`define CFG_DATA_W 16

`endif

//--- rtl/cnn_sender_pkg.sv
// sender types: fixed-point value, tracker states and config register map

`default_nettype none

`include "cnn_sender_defines.svh"

package cnn_sender_pkg;

    // X.XXXX_XXXX_XXXX_XXX with bit 15 as the sign
    typedef logic [`FMAP_W-1:0] fmap_t;

    // rows 0 and 1 only fill the line buffers, later rows produce windows
    typedef enum logic
    {
        FILL_LINE_BUF = 1'b0,
        SEND_WINDOWS  = 1'b1
    } sender_state_e;

    typedef enum logic [`CFG_ADDR_W-1:0]
    {
        REG_IMG_WIDTH   = 2'd0,
        REG_IMG_HEIGHT  = 2'd1,
        REG_WT_BASE     = 2'd2,
        REG_FRAME_COUNT = 2'd3
    } cfg_reg_e;

endpackage

`default_nettype wire

//--- rtl/cnn_sender_top.sv
// CNN first-layer sender: turns a pixel stream into 3x3 windows for the MAC array

`timescale 1ns/10ps
`default_nettype none

`include "cnn_sender_defines.svh"

module cnn_sender_top
(
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic [`PIXEL_W-1:0]    pixel_i,
    input  wire logic                   pixel_valid_i,
    input  wire logic                   cfg_we_i,
    input  wire logic [`CFG_ADDR_W-1:0] cfg_addr_i,
    input  wire logic [`CFG_DATA_W-1:0] cfg_wdata_i,
    output logic      [`CFG_DATA_W-1:0] cfg_rdata_o,
    output logic      [`WINDOW_W-1:0]   window_o,
    output logic                        window_valid_o,
    output logic                        frame_done_o,
    output logic      [`WT_ADDR_W-1:0]  wt_addr_a_o,
    output logic      [`WT_ADDR_W-1:0]  wt_addr_b_o
);

    cnn_sender_pkg::fmap_t pixel_fmap;
    cnn_sender_pkg::fmap_t upper;
    cnn_sender_pkg::fmap_t middle;
    logic [`COORD_W:0]     img_width;
    logic [`COORD_W:0]     img_height;
    logic [`COORD_W-1:0]   col;
    logic                  row_sel;
    logic                  window_ok;
    logic                  frame_active;
    logic                  frame_done;

    // grayscale pixel scaled by 1/256 into the positive fixed-point range
    assign pixel_fmap = {1'b0, pixel_i, {(`FMAP_W - `PIXEL_W - 1){1'b0}}};

    sender_config_regs u_config_regs (
        .clk            (clk),
        .rst            (rst),
        .cfg_we_i       (cfg_we_i),
        .cfg_addr_i     (cfg_addr_i),
        .cfg_wdata_i    (cfg_wdata_i),
        .frame_active_i (frame_active),
        .frame_done_i   (frame_done),
        .cfg_rdata_o    (cfg_rdata_o),
        .img_width_o    (img_width),
        .img_height_o   (img_height),
        .wt_addr_a_o    (wt_addr_a_o),
        .wt_addr_b_o    (wt_addr_b_o)
    );

    pixel_position_tracker u_tracker (
        .clk            (clk),
        .rst            (rst),
        .pixel_valid_i  (pixel_valid_i),
        .img_width_i    (img_width),
        .img_height_i   (img_height),
        .col_o          (col),
        .row_sel_o      (row_sel),
        .window_ok_o    (window_ok),
        .frame_active_o (frame_active),
        .frame_done_o   (frame_done)
    );

    line_buffer_pair u_line_buffers (
        .clk       (clk),
        .rst       (rst),
        .wr_en_i   (pixel_valid_i),
        .col_i     (col),
        .row_sel_i (row_sel),
        .pixel_i   (pixel_fmap),
        .upper_o   (upper),
        .middle_o  (middle)
    );

    sliding_window u_window (
        .clk            (clk),
        .rst            (rst),
        .shift_i        (pixel_valid_i),
        .window_ok_i    (window_ok),
        .upper_i        (upper),
        .middle_i       (middle),
        .bottom_i       (pixel_fmap),
        .window_o       (window_o),
        .window_valid_o (window_valid_o)
    );

    // delayed by one cycle so it lines up with the last window of the frame
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            frame_done_o <= 1'b0;
        else
            frame_done_o <= frame_done;
    end

endmodule

`default_nettype wire

//--- rtl/line_buffer_pair.sv
// ping-pong line buffers holding the two rows above the incoming pixel

`timescale 1ns/10ps
`default_nettype none

`include "cnn_sender_defines.svh"

module line_buffer_pair
(
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  wr_en_i,
    input  wire logic [`COORD_W-1:0]   col_i,
    input  wire logic                  row_sel_i,
    input  wire cnn_sender_pkg::fmap_t pixel_i,
    output cnn_sender_pkg::fmap_t      upper_o,
    output cnn_sender_pkg::fmap_t      middle_o
);

    // mem[row_sel] holds the previous row, the other one the row before it
    cnn_sender_pkg::fmap_t mem [2][`MAX_IMG_DIM];

    // asynchronous read so the column is available in the cycle of its pixel
    assign upper_o  = mem[~row_sel_i][col_i];
    assign middle_o = mem[row_sel_i][col_i];

    // the oldest value at this column has just been read out and can go
    always_ff @(posedge clk)
    begin
        if (wr_en_i)
            mem[~row_sel_i][col_i] <= pixel_i;
    end

    // the tracker must never address past the end of a row
    col_in_depth_a: assert property (@(posedge clk) disable iff (rst)
        wr_en_i |-> col_i < `MAX_IMG_DIM);

endmodule

`default_nettype wire

//--- rtl/pixel_position_tracker.sv
// pixel position tracker: column/row counters, ping-pong row select and window decision

`timescale 1ns/10ps
`default_nettype none

`include "cnn_sender_defines.svh"

module pixel_position_tracker
(
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               pixel_valid_i,
    input  wire logic [`COORD_W:0]  img_width_i,
    input  wire logic [`COORD_W:0]  img_height_i,
    output logic      [`COORD_W-1:0] col_o,
    output logic                    row_sel_o,
    output logic                    window_ok_o,
    output logic                    frame_active_o,
    output logic                    frame_done_o
);

    cnn_sender_pkg::sender_state_e state;
    logic [`COORD_W-1:0] row;
    logic                last_col;
    logic                last_row;

    assign last_col = ({1'b0, col_o} == img_width_i - 1'b1);
    assign last_row = ({1'b0, row} == img_height_i - 1'b1);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            col_o          <= '0;
            row            <= '0;
            row_sel_o      <= 1'b0;
            state          <= cnn_sender_pkg::FILL_LINE_BUF;
            frame_active_o <= 1'b0;
        end
        else if (pixel_valid_i)
        begin
            // the frame stays active from its first pixel up to its last one
            frame_active_o <= !(last_col && last_row);
            if (last_col)
            begin
                col_o <= '0;
                if (last_row)
                begin
                    row       <= '0;
                    row_sel_o <= 1'b0;
                    state     <= cnn_sender_pkg::FILL_LINE_BUF;
                end
                else
                begin
                    row       <= row + 1'b1;
                    // the row just finished becomes the previous row for the next one
                    row_sel_o <= ~row_sel_o;
                    if (row == `KERNEL_DIM - 2)
                        state <= cnn_sender_pkg::SEND_WINDOWS;
                end
            end
            else
            begin
                col_o <= col_o + 1'b1;
            end
        end
    end

    // the newest pixel is the bottom-right corner, so it needs two columns to its left
    assign window_ok_o = pixel_valid_i
                      && (state == cnn_sender_pkg::SEND_WINDOWS)
                      && (col_o >= `KERNEL_DIM - 1);

    assign frame_done_o = pixel_valid_i && last_col && last_row;

    // relies on the config block keeping the geometry still during a frame
    col_in_range_a: assert property (@(posedge clk) disable iff (rst)
        {1'b0, col_o} < img_width_i);

endmodule

`default_nettype wire

//--- rtl/sender_config_regs.sv
// sender config block holding the image geometry, the weight base and the finished frame count

`timescale 1ns/10ps
`default_nettype none

`include "cnn_sender_defines.svh"

module sender_config_regs
(
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   cfg_we_i,
    input  wire logic [`CFG_ADDR_W-1:0] cfg_addr_i,
    input  wire logic [`CFG_DATA_W-1:0] cfg_wdata_i,
    input  wire logic                   frame_active_i,
    input  wire logic                   frame_done_i,
    output logic      [`CFG_DATA_W-1:0] cfg_rdata_o,
    output logic      [`COORD_W:0]      img_width_o,
    output logic      [`COORD_W:0]      img_height_o,
    output logic      [`WT_ADDR_W-1:0]  wt_addr_a_o,
    output logic      [`WT_ADDR_W-1:0]  wt_addr_b_o
);

    logic [`CFG_DATA_W-1:0] frame_count;

    // a side must hold at least one window and fit in the line buffers
    function automatic logic [`COORD_W:0] clamp_dim(input logic [`CFG_DATA_W-1:0] value);
        logic [`COORD_W:0] result;
        if (value > `MAX_IMG_DIM)
            result = (`COORD_W + 1)'(`MAX_IMG_DIM);
        else if (value < `KERNEL_DIM)
            result = (`COORD_W + 1)'(`KERNEL_DIM);
        else
            result = value[`COORD_W:0];
        return result;
    endfunction

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            img_width_o  <= (`COORD_W + 1)'(`MAX_IMG_DIM);
            img_height_o <= (`COORD_W + 1)'(`MAX_IMG_DIM);
            wt_addr_a_o  <= '0;
            frame_count  <= '0;
        end
        else
        begin
            // geometry and base are locked while pixels of a frame are arriving
            if (cfg_we_i && !frame_active_i)
            begin
                case (cnn_sender_pkg::cfg_reg_e'(cfg_addr_i))
                    cnn_sender_pkg::REG_IMG_WIDTH:  img_width_o  <= clamp_dim(cfg_wdata_i);
                    cnn_sender_pkg::REG_IMG_HEIGHT: img_height_o <= clamp_dim(cfg_wdata_i);
                    cnn_sender_pkg::REG_WT_BASE:    wt_addr_a_o  <= cfg_wdata_i[`WT_ADDR_W-1:0];
                    default:                        ;
                endcase
            end
            if (frame_done_i)
                frame_count <= frame_count + 1'b1;
        end
    end

    // the second weight bank sits right after the first
    assign wt_addr_b_o = wt_addr_a_o + 1'b1;

    always_comb
    begin
        cfg_rdata_o = '0;
        case (cnn_sender_pkg::cfg_reg_e'(cfg_addr_i))
            cnn_sender_pkg::REG_IMG_WIDTH:   cfg_rdata_o[`COORD_W:0]     = img_width_o;
            cnn_sender_pkg::REG_IMG_HEIGHT:  cfg_rdata_o[`COORD_W:0]     = img_height_o;
            cnn_sender_pkg::REG_WT_BASE:     cfg_rdata_o[`WT_ADDR_W-1:0] = wt_addr_a_o;
            cnn_sender_pkg::REG_FRAME_COUNT: cfg_rdata_o                 = frame_count;
            default:                         cfg_rdata_o                 = '0;
        endcase
    end

    // the tracker relies on a geometry that holds from the first pixel of a frame to its last
    geometry_locked_a: assert property (@(posedge clk) disable iff (rst)
        frame_active_i |-> $stable(img_width_o) && $stable(img_height_o));

endmodule

`default_nettype wire

//--- rtl/sliding_window.sv
// 3x3 sliding window that shifts in pixel columns and packs the window output

`timescale 1ns/10ps
`default_nettype none

`include "cnn_sender_defines.svh"

module sliding_window
(
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  shift_i,
    input  wire logic                  window_ok_i,
    input  wire cnn_sender_pkg::fmap_t upper_i,
    input  wire cnn_sender_pkg::fmap_t middle_i,
    input  wire cnn_sender_pkg::fmap_t bottom_i,
    output logic [`WINDOW_W-1:0]       window_o,
    output logic                       window_valid_o
);

    // win[row][col] with row 0 at the top and col 0 on the left
    cnn_sender_pkg::fmap_t win [`KERNEL_DIM][`KERNEL_DIM];

    always_ff @(posedge clk)
    begin
        if (shift_i)
        begin
            for (int r = 0; r < `KERNEL_DIM; r++)
            begin
                for (int c = 0; c < `KERNEL_DIM - 1; c++)
                begin
                    win[r][c] <= win[r][c+1];
                end
            end
            win[0][`KERNEL_DIM-1] <= upper_i;
            win[1][`KERNEL_DIM-1] <= middle_i;
            win[2][`KERNEL_DIM-1] <= bottom_i;
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            window_valid_o <= 1'b0;
        else
            window_valid_o <= shift_i && window_ok_i;
    end

    // window_o comes straight from the window flops, top-left in the top bits
    always_comb
    begin
        for (int r = 0; r < `KERNEL_DIM; r++)
        begin
            for (int c = 0; c < `KERNEL_DIM; c++)
            begin
                window_o[(`KERNEL_DIM * `KERNEL_DIM - 1 - (r * `KERNEL_DIM + c)) * `FMAP_W
                         +: `FMAP_W] = win[r][c];
            end
        end
    end

    // a window is only sent once the line buffers and the window flops hold real pixels
    window_known_a: assert property (@(posedge clk) disable iff (rst)
        window_valid_o |-> !$isunknown(window_o));

endmodule

`default_nettype wire

//--- sources.f
+incdir+rtl
rtl/cnn_sender_pkg.sv
rtl/sender_config_regs.sv
rtl/pixel_position_tracker.sv
rtl/line_buffer_pair.sv
rtl/sliding_window.sv
rtl/cnn_sender_top.sv
testbench/sender_checker.sv
testbench/tb_cnn_sender.sv

//--- testbench/sender_checker.sv
// sender checker: image model of the window former that compares every DUT output

`timescale 1ns/10ps
`default_nettype none

`include "cnn_sender_defines.svh"

module sender_checker
(
    input wire logic                   clk,
    input wire logic                   rst,
    input wire logic [`PIXEL_W-1:0]    pixel_i,
    input wire logic                   pixel_valid_i,
    input wire logic [`CFG_DATA_W-1:0] cfg_rdata_i,
    input wire logic [`WINDOW_W-1:0]   window_i,
    input wire logic                   window_valid_i,
    input wire logic                   frame_done_i,
    input wire logic [`WT_ADDR_W-1:0]  wt_addr_a_i,
    input wire logic [`WT_ADDR_W-1:0]  wt_addr_b_i
);

    logic [`PIXEL_W-1:0]  image [`MAX_IMG_DIM][`MAX_IMG_DIM];
    logic [255:0]         test_name;
    logic                 want_window = 1'b0;
    logic                 want_done = 1'b0;
    logic [`WINDOW_W-1:0] want_data;
    int width = `MAX_IMG_DIM;
    int height = `MAX_IMG_DIM;
    int col = 0;
    int row = 0;
    int expected_windows = 0;
    int windows_seen = 0;
    int frames_seen = 0;
    int test_errors = 0;
    int error_count = 0;
    int tests_run = 0;
    int tests_failed = 0;

    // sign bit clear, the pixel, then seven fraction bits
    function automatic logic [`FMAP_W-1:0] widen(input logic [`PIXEL_W-1:0] pixel);
        return {1'b0, pixel, {(`FMAP_W - `PIXEL_W - 1){1'b0}}};
    endfunction

    task automatic report(input string what, input logic [`WINDOW_W-1:0] expected,
                          input logic [`WINDOW_W-1:0] actual);
        $display("[FAIL] %0s %0s: expected %0h, actual %0h", test_name, what, expected, actual);
        test_errors++;
        error_count++;
    endtask

    task automatic start_test(input logic [255:0] name, input int w, input int h, input int count);
        test_name = name;
        width = w;
        height = h;
        expected_windows = count;
        windows_seen = 0;
        frames_seen = 0;
        test_errors = 0;
        col = 0;
        row = 0;
        if (count != (w - 2) * (h - 2))
            report("vector file window count", (w - 2) * (h - 2), count);
    endtask

    task automatic check_reg(input string label, input logic [`CFG_DATA_W-1:0] expected);
        if (cfg_rdata_i !== expected)
            report(label, expected, cfg_rdata_i);
    endtask

    task automatic check_weights(input logic [`WT_ADDR_W-1:0] base);
        if (wt_addr_a_i !== base)
            report("wt_addr_a", base, wt_addr_a_i);
        if (wt_addr_b_i !== base + 1'b1)
            report("wt_addr_b", base + 1'b1, wt_addr_b_i);
    endtask

    task automatic finish_test();
        if (windows_seen != expected_windows)
            report("window count", expected_windows, windows_seen);
        if (frames_seen != 1)
            report("frame_done pulses", 1, frames_seen);
        tests_run++;
        if (test_errors != 0)
        begin
            tests_failed++;
            $display("%0s: failed with %0d errors", test_name, test_errors);
        end
        else
            $display("%0s: passed, %0d windows", test_name, windows_seen);
    endtask

    // outputs seen at an edge belong to the pixel accepted at the edge before
    always @(posedge clk)
    begin
        if (!rst)
        begin
            if (window_valid_i !== want_window)
                report("window_valid", want_window, window_valid_i);
            else if (want_window && window_i !== want_data)
                report("window", want_data, window_i);
            if (frame_done_i !== want_done)
                report("frame_done", want_done, frame_done_i);
            windows_seen += (window_valid_i === 1'b1);
            frames_seen += (frame_done_i === 1'b1);
            want_window = 1'b0;
            want_done = 1'b0;
            if (pixel_valid_i)
            begin
                image[row][col] = pixel_i;
                if (row >= 2 && col >= 2)
                begin
                    want_window = 1'b1;
                    for (int r = row - 2; r <= row; r++)
                        for (int c = col - 2; c <= col; c++)
                            want_data = {want_data[`WINDOW_W-`FMAP_W-1:0], widen(image[r][c])};
                end
                want_done = (col == width - 1) && (row == height - 1);
                row = (col == width - 1) ? (want_done ? 0 : row + 1) : row;
                col = (col == width - 1) ? 0 : col + 1;
            end
        end
    end

endmodule

`default_nettype wire

//--- testbench/sender_vectors.txt
# columns: name width height weight_base(hex) lfsr_seed(hex) gap_mode expected_windows
# gap_mode 1 drops the pixel strobe at random, expected_windows is (width-2)*(height-2)
full_30x30 30 30 000 00002418 0 784
gap_30x30 30 30 1f0 00002418 1 784
small_5x7 5 7 7fe 00002418 0 15
small_5x7_gap 5 7 123 00002418 1 15
min_3x3 3 3 010 00002418 0 1
wide_30x4 30 4 2aa 00002418 1 56
tall_4x30 4 30 055 00002418 0 56
odd_17x11 17 11 3ff 00002418 1 135

//--- testbench/tb_cnn_sender.sv
// testbench for the CNN first-layer sender: config writes, pixel frames and summary

`timescale 1ns/10ps
`default_nettype none

`include "cnn_sender_defines.svh"

module tb_cnn_sender;

    logic                   clk;
    logic                   rst;
    logic [`PIXEL_W-1:0]    pixel_i;
    logic                   pixel_valid_i;
    logic                   cfg_we_i;
    logic [`CFG_ADDR_W-1:0] cfg_addr_i;
    logic [`CFG_DATA_W-1:0] cfg_wdata_i;
    logic [`CFG_DATA_W-1:0] cfg_rdata_o;
    logic [`WINDOW_W-1:0]   window_o;
    logic                   window_valid_o;
    logic                   frame_done_o;
    logic [`WT_ADDR_W-1:0]  wt_addr_a_o;
    logic [`WT_ADDR_W-1:0]  wt_addr_b_o;

    logic [255:0] names [16];
    int           widths [16];
    int           heights [16];
    logic [31:0]  bases [16];
    logic [31:0]  seeds [16];
    int           gaps [16];
    int           counts [16];
    int           num_tests;
    int           budget;
    logic [31:0]  lfsr;

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    cnn_sender_top dut (.*);

    sender_checker chk (
        .clk            (clk),
        .rst            (rst),
        .pixel_i        (pixel_i),
        .pixel_valid_i  (pixel_valid_i),
        .cfg_rdata_i    (cfg_rdata_o),
        .window_i       (window_o),
        .window_valid_i (window_valid_o),
        .frame_done_i   (frame_done_o),
        .wt_addr_a_i    (wt_addr_a_o),
        .wt_addr_b_i    (wt_addr_b_o)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0])
            next = next ^ 32'hA300_0000;
        return next;
    endfunction

    task automatic take_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            value = {value[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic load_vectors();
        int          fd;
        logic [1023:0] line;
        num_tests = 0;
        fd = $fopen("testbench/sender_vectors.txt", "r");
        if (fd == 0)
            $display("could not open the vector file");
        while (fd != 0 && $fgets(line, fd) != 0 && num_tests < 16)
        begin
            // comment lines fail the match and are skipped
            if ($sscanf(line, "%s %d %d %h %h %d %d", names[num_tests], widths[num_tests],
                        heights[num_tests], bases[num_tests], seeds[num_tests],
                        gaps[num_tests], counts[num_tests]) == 7)
                num_tests++;
        end
        if (fd != 0)
            $fclose(fd);
    endtask

    task automatic write_reg(input logic [`CFG_ADDR_W-1:0] addr, input int data);
        @(posedge clk);
        #1;
        cfg_we_i = 1'b1;
        cfg_addr_i = addr;
        cfg_wdata_i = data[`CFG_DATA_W-1:0];
        @(posedge clk);
        #1;
        cfg_we_i = 1'b0;
    endtask

    task automatic read_check(input logic [`CFG_ADDR_W-1:0] addr, input string label,
                              input int expected);
        @(posedge clk);
        #1;
        cfg_addr_i = addr;
        #1;
        chk.check_reg(label, expected[`CFG_DATA_W-1:0]);
    endtask

    task automatic run_frame(input int pixels, input int gap);
        logic [31:0] bits;
        for (int i = 0; i < pixels; i++)
        begin
            bits = 32'h1;
            while (gap != 0 && bits[0])
            begin
                take_bits(1, bits);
                if (bits[0])
                begin
                    @(posedge clk);
                    #1;
                    pixel_valid_i = 1'b0;
                    cfg_we_i = 1'b0;
                end
            end
            take_bits(8, bits);
            @(posedge clk);
            #1;
            pixel_valid_i = 1'b1;
            pixel_i = bits[`PIXEL_W-1:0];
            // a width write halfway through the frame has to be ignored
            cfg_we_i = (i == pixels / 2);
            cfg_addr_i = cnn_sender_pkg::REG_IMG_WIDTH;
            cfg_wdata_i = 16'd9;
        end
        @(posedge clk);
        #1;
        pixel_valid_i = 1'b0;
        cfg_we_i = 1'b0;
        do
            @(posedge clk);
        while (frame_done_o !== 1'b1);
    endtask

    initial
    begin
        rst = 1'b1;
        pixel_i = '0;
        pixel_valid_i = 1'b0;
        cfg_we_i = 1'b0;
        cfg_addr_i = '0;
        cfg_wdata_i = '0;
        lfsr = 32'h2418;
        load_vectors();
        if (num_tests == 0)
        begin
            $display("no usable test was found in the vector file");
            $display("SOME TESTS FAILED");
            $finish;
        end
        else
        begin
            // gap tests average one idle cycle per pixel
            budget = 1000;
            for (int t = 0; t < num_tests; t++)
                budget += 2 * widths[t] * heights[t] * (gaps[t] != 0 ? 2 : 1) + 100;
            fork
                begin
                    #(budget * 10);
                    $display("watchdog expired after %0d cycles, the run did not finish", budget);
                    $display("SOME TESTS FAILED");
                    $finish;
                end
            join_none
            repeat (10) @(posedge clk);
            #1;
            rst = 1'b0;
            for (int t = 0; t < num_tests; t++)
            begin
                lfsr = seeds[t];
                chk.start_test(names[t], widths[t], heights[t], counts[t]);
                write_reg(cnn_sender_pkg::REG_IMG_WIDTH, widths[t]);
                write_reg(cnn_sender_pkg::REG_IMG_HEIGHT, heights[t]);
                write_reg(cnn_sender_pkg::REG_WT_BASE, bases[t]);
                read_check(cnn_sender_pkg::REG_WT_BASE, "weight base", bases[t]);
                chk.check_weights(bases[t][`WT_ADDR_W-1:0]);
                run_frame(widths[t] * heights[t], gaps[t]);
                read_check(cnn_sender_pkg::REG_IMG_WIDTH, "locked width", widths[t]);
                read_check(cnn_sender_pkg::REG_IMG_HEIGHT, "locked height", heights[t]);
                read_check(cnn_sender_pkg::REG_FRAME_COUNT, "frame count", t + 1);
                chk.finish_test();
            end
            $display("tests run %0d, tests failed %0d, errors %0d",
                     chk.tests_run, chk.tests_failed, chk.error_count);
            if (chk.error_count == 0 && chk.tests_run == num_tests)
                $display("ALL TESTS PASSED");
            else
                $display("SOME TESTS FAILED");
            $finish;
        end
    end

endmodule

`default_nettype wire
